// File: source/pet_bus_macros.svh
// Widths and frame constants shared by the bus; FRAME_CYCLES must stay a power of two
`ifndef PET_BUS_MACROS_SVH
`define PET_BUS_MACROS_SVH

`define CPU_ADDR_WIDTH 16           // 6502 address bus
`define RAM_ADDR_WIDTH 17           // 128 KB RAM, upper half host only
`define DATA_WIDTH 8

// Bus frame layout in system clocks
`define FRAME_CYCLES 16             // 64 MHz / 16 gives a 4 MHz CPU
`define CPU_SLOT_START 8            // First count of the CPU half
`define CPU_CLOCK_START 12          // CPU phase 2 rises here

// Counts 1 to 4 of the host slot drive the RAM
`define RAM_ACCESS_CYCLES 4

`endif

// File: source/pet_bus_pkg.sv
// Shared bus types; the chip select fields assume a single-CPU PET memory map
`default_nettype none

package pet_bus_pkg;

    // Chip selects produced by the CPU address decoder
    typedef struct packed {
        logic ram;
        logic readonly;     // ROM region, CPU writes are dropped
        logic io;           // Page E8
        logic pia1;
        logic pia2;
        logic via;
        logic crtc;
        logic valid;        // Copy of cpu_be
    } chip_select_t;

    // Owner of the RAM in the current half frame
    typedef enum logic {
        SLOT_HOST,
        SLOT_CPU
    } bus_slot_e;

endpackage

`default_nettype wire

// File: source/wb_if.sv
// Pipelined Wishbone with an 8-bit data path; no clock inside, the users share sys_clock_i
`default_nettype none

`include "pet_bus_macros.svh"

interface wb_if;

    logic [`RAM_ADDR_WIDTH-1:0] addr;
    logic [    `DATA_WIDTH-1:0] wdata;     // Host to RAM
    logic [    `DATA_WIDTH-1:0] rdata;     // RAM to host
    logic                       we;
    logic                       cyc;
    logic                       stb;
    logic                       stall;
    logic                       ack;

    // Host side
    modport controller (output addr, wdata, we, cyc, stb, input rdata, stall, ack);

    // RAM bridge side
    modport target (input addr, wdata, we, cyc, stb, output rdata, stall, ack);

endinterface

`default_nettype wire

// File: source/slot_timer.sv
// Free-running bus frame timer; the first frame after reset gives the host no grant
`default_nettype none

`include "pet_bus_macros.svh"

module slot_timer (
    input  logic                  sys_clock_i,
    input  logic                  sys_reset_ni,
    output pet_bus_pkg::bus_slot_e slot_o,
    output logic                  cpu_be_o,
    output logic                  cpu_clock_o,
    output logic                  grant_strobe_o
);
    import pet_bus_pkg::*;

    localparam int COUNT_WIDTH = $clog2(`FRAME_CYCLES);
    localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(`FRAME_CYCLES - 1);

    logic [COUNT_WIDTH-1:0] frame_count;
    logic [COUNT_WIDTH-1:0] next_count;

    assign next_count = (frame_count == LAST_COUNT) ? '0 : frame_count + 1'b1;

    // Outputs decode next_count so they line up with frame_count
    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            frame_count    <= '0;
            slot_o         <= SLOT_HOST;
            cpu_be_o       <= 1'b0;
            cpu_clock_o    <= 1'b0;
            grant_strobe_o <= 1'b0;
        end else begin
            frame_count    <= next_count;
            slot_o         <= (next_count >= `CPU_SLOT_START) ? SLOT_CPU : SLOT_HOST;
            cpu_be_o       <= (next_count >= `CPU_SLOT_START);   // CPU half of frame
            cpu_clock_o    <= (next_count >= `CPU_CLOCK_START);  // Phase 2
            grant_strobe_o <= (next_count == '0);                // Host grant
        end
    end

endmodule

`default_nettype wire

// File: source/cpu_address_decoder.sv
// PET map decode without mirroring or expansion RAM; the I/O page is fixed at E8
`default_nettype none

`include "pet_bus_macros.svh"

module cpu_address_decoder (
    input  logic [`CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic                       cpu_be_i,
    output pet_bus_pkg::chip_select_t  cs_o
);

    localparam logic [7:0] IO_PAGE = 8'hE8;
    localparam logic [`CPU_ADDR_WIDTH-1:0] ROM_BASE = 16'h9000;    // Start of ROM region

    logic io_page;
    logic rom_region;

    assign io_page    = (cpu_addr_i[15:8] == IO_PAGE);
    assign rom_region = (cpu_addr_i >= ROM_BASE);

    always_comb begin
        cs_o       = '0;
        cs_o.valid = cpu_be_i;

        if (cpu_be_i) begin
            if (io_page) begin
                // One-hot style select lines, as on the real board
                cs_o.io   = 1'b1;
                cs_o.pia1 = cpu_addr_i[4];
                cs_o.pia2 = cpu_addr_i[5];
                cs_o.via  = cpu_addr_i[6];
                cs_o.crtc = cpu_addr_i[7];
            end else begin
                cs_o.ram      = 1'b1;
                cs_o.readonly = rom_region;    // Editor, BASIC and kernal ROM images
            end
        end
    end

endmodule

`default_nettype wire

// File: source/wb_ram_bridge.sv
// One host access per frame; requests wait with stall high until the next grant
`default_nettype none

`include "pet_bus_macros.svh"

module wb_ram_bridge (
    input  logic                       sys_clock_i,
    input  logic                       sys_reset_ni,
    wb_if.target                       wb,
    input  pet_bus_pkg::bus_slot_e     slot_i,
    input  logic                       grant_strobe_i,
    output logic [`RAM_ADDR_WIDTH-1:0] ram_addr_o,
    output logic                       ram_oe_o,
    output logic                       ram_we_o,
    output logic [    `DATA_WIDTH-1:0] ram_wdata_o,
    input  logic [    `DATA_WIDTH-1:0] ram_data_i
);
    import pet_bus_pkg::*;

    localparam int ACCESS_WIDTH = $clog2(`RAM_ACCESS_CYCLES);
    localparam logic [ACCESS_WIDTH-1:0] LAST_ACCESS = ACCESS_WIDTH'(`RAM_ACCESS_CYCLES - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_ACK
    } state_e;

    state_e                     state;
    logic [ACCESS_WIDTH-1:0]    access_count;
    logic                       accept;
    logic                       host_slot;

    // Request payload, captured at the grant
    logic [`RAM_ADDR_WIDTH-1:0] addr_q;
    logic [    `DATA_WIDTH-1:0] wdata_q;
    logic [    `DATA_WIDTH-1:0] rdata_q;
    logic                       we_q;

    assign wb.stall  = !(grant_strobe_i && state == ST_IDLE);
    assign accept    = wb.cyc && wb.stb && !wb.stall;
    assign host_slot = (slot_i == SLOT_HOST);

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            state        <= ST_IDLE;
            access_count <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    access_count <= '0;
                    if (accept) state <= ST_ACCESS;
                end
                ST_ACCESS: begin
                    access_count <= access_count + 1'b1;
                    if (access_count == LAST_ACCESS) state <= ST_ACK;  // Frame count 4
                end
                default: state <= ST_IDLE;      // ST_ACK lasts one cycle
            endcase
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (accept) begin
            addr_q  <= wb.addr;
            wdata_q <= wb.wdata;
            we_q    <= wb.we;
        end
        if (state == ST_ACCESS && access_count == LAST_ACCESS) rdata_q <= ram_data_i;
    end

    // Strobes stay inside the host half of the frame
    assign ram_oe_o    = (state == ST_ACCESS) && !we_q && host_slot;
    assign ram_we_o    = (state == ST_ACCESS) &&  we_q && host_slot;
    assign ram_addr_o  = addr_q;
    assign ram_wdata_o = wdata_q;

    assign wb.ack   = (state == ST_ACK);
    assign wb.rdata = rdata_q;

endmodule

`default_nettype wire

// File: source/bus_combiner.sv
// Combinational merge of CPU and host controls; assumes the two never overlap in a frame
`default_nettype none

`include "pet_bus_macros.svh"

module bus_combiner (
    input  pet_bus_pkg::chip_select_t  cs_i,
    input  logic [`CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic                       cpu_we_i,
    input  logic                       cpu_clock_i,
    input  logic [`RAM_ADDR_WIDTH-1:0] bridge_addr_i,
    input  logic                       bridge_oe_i,
    input  logic                       bridge_we_i,
    input  logic [    `DATA_WIDTH-1:0] bridge_wdata_i,

    output logic [`RAM_ADDR_WIDTH-1:0] ram_addr_o,
    output logic                       ram_oe_o,
    output logic                       ram_we_o,
    output logic                       io_oe_o,
    output logic                       pia1_cs_o,
    output logic                       pia2_cs_o,
    output logic                       via_cs_o,
    output logic                       crtc_cs_o,
    output logic [    `DATA_WIDTH-1:0] cpu_data_o,
    output logic                       cpu_data_oe_o
);

    logic cpu_rd_strobe;
    logic cpu_wr_strobe;

    assign cpu_rd_strobe = cs_i.valid && !cpu_we_i;
    assign cpu_wr_strobe = cs_i.valid &&  cpu_we_i && cpu_clock_i;   // Write during phase 2

    // CPU only sees the lower 64 KB
    assign ram_addr_o = cs_i.valid ? {1'b0, cpu_addr_i} : bridge_addr_i;

    assign ram_oe_o = (cpu_rd_strobe && cs_i.ram) || bridge_oe_i;
    assign ram_we_o = (cpu_wr_strobe && cs_i.ram && !cs_i.readonly) || bridge_we_i;

    // Peripheral selects already carry cpu_be from the decoder
    assign io_oe_o   = cs_i.io;
    assign pia1_cs_o = cs_i.pia1;
    assign pia2_cs_o = cs_i.pia2;
    assign via_cs_o  = cs_i.via;
    assign crtc_cs_o = cs_i.crtc;

    // FPGA drives the shared data bus only for host writes
    assign cpu_data_o    = bridge_wdata_i;
    assign cpu_data_oe_o = bridge_we_i;

endmodule

`default_nettype wire

// File: source/pet_bus_top.sv
// Shared RAM bus top; the CPU must follow cpu_be_o and cpu_clock_o, and RAM data arrives on ram_data_i
`default_nettype none

`include "pet_bus_macros.svh"

module pet_bus_top (
    input  logic                       sys_clock_i,
    input  logic                       sys_reset_ni,

    input  logic [`CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic                       cpu_we_i,
    output logic                       cpu_be_o,
    output logic                       cpu_clock_o,

    input  logic [`RAM_ADDR_WIDTH-1:0] wb_addr_i,
    input  logic [    `DATA_WIDTH-1:0] wb_data_i,
    input  logic                       wb_we_i,
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    output logic [    `DATA_WIDTH-1:0] wb_data_o,
    output logic                       wb_stall_o,
    output logic                       wb_ack_o,

    input  logic [    `DATA_WIDTH-1:0] ram_data_i,
    output logic [`RAM_ADDR_WIDTH-1:0] ram_addr_o,
    output logic                       ram_oe_o,
    output logic                       ram_we_o,
    output logic [    `DATA_WIDTH-1:0] cpu_data_o,
    output logic                       cpu_data_oe_o,

    output logic                       io_oe_o,
    output logic                       pia1_cs_o,
    output logic                       pia2_cs_o,
    output logic                       via_cs_o,
    output logic                       crtc_cs_o
);
    import pet_bus_pkg::*;

    bus_slot_e                  slot;
    logic                       grant_strobe;
    chip_select_t               cs;

    logic [`RAM_ADDR_WIDTH-1:0] bridge_addr;
    logic                       bridge_oe;
    logic                       bridge_we;
    logic [    `DATA_WIDTH-1:0] bridge_wdata;

    wb_if wb_bus ();

    // Host port into the interface
    assign wb_bus.addr  = wb_addr_i;
    assign wb_bus.wdata = wb_data_i;
    assign wb_bus.we    = wb_we_i;
    assign wb_bus.cyc   = wb_cyc_i;
    assign wb_bus.stb   = wb_stb_i;
    assign wb_data_o    = wb_bus.rdata;
    assign wb_stall_o   = wb_bus.stall;
    assign wb_ack_o     = wb_bus.ack;

    slot_timer u_slot_timer (
        .sys_clock_i(sys_clock_i), .sys_reset_ni(sys_reset_ni), .slot_o(slot),
        .cpu_be_o(cpu_be_o), .cpu_clock_o(cpu_clock_o), .grant_strobe_o(grant_strobe)
    );

    cpu_address_decoder u_cpu_address_decoder (
        .cpu_addr_i(cpu_addr_i), .cpu_be_i(cpu_be_o), .cs_o(cs)
    );

    wb_ram_bridge u_wb_ram_bridge (
        .sys_clock_i(sys_clock_i), .sys_reset_ni(sys_reset_ni), .wb(wb_bus.target),
        .slot_i(slot), .grant_strobe_i(grant_strobe), .ram_addr_o(bridge_addr),
        .ram_oe_o(bridge_oe), .ram_we_o(bridge_we), .ram_wdata_o(bridge_wdata),
        .ram_data_i(ram_data_i)
    );

    bus_combiner u_bus_combiner (
        .cs_i(cs), .cpu_addr_i(cpu_addr_i), .cpu_we_i(cpu_we_i), .cpu_clock_i(cpu_clock_o),
        .bridge_addr_i(bridge_addr), .bridge_oe_i(bridge_oe), .bridge_we_i(bridge_we),
        .bridge_wdata_i(bridge_wdata), .ram_addr_o(ram_addr_o), .ram_oe_o(ram_oe_o),
        .ram_we_o(ram_we_o), .io_oe_o(io_oe_o), .pia1_cs_o(pia1_cs_o), .pia2_cs_o(pia2_cs_o),
        .via_cs_o(via_cs_o), .crtc_cs_o(crtc_cs_o), .cpu_data_o(cpu_data_o),
        .cpu_data_oe_o(cpu_data_oe_o)
    );

endmodule

`default_nettype wire

// File: verification/clock_gen.sv
// 40 ns free-running clock; reset is held low for 16 cycles and released on a falling edge
`default_nettype none

module clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clock_o,
    output logic reset_no
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clock_o = 1'b0;
        forever #20 clock_o = ~clock_o;     // 25 MHz in simulation time
    end

    initial begin
        reset_no = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock_o);
        reset_no = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/pet_bus_checker.sv
// Bus exclusion properties for pet_bus_top; every property is off while reset is low
`default_nettype none

module pet_bus_checker (
    input logic clock_i,
    input logic reset_ni,
    input logic cpu_be_i,
    input logic bridge_oe_i,
    input logic bridge_we_i,
    input logic io_oe_i,
    input logic ram_oe_i,
    input logic ack_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int violation_count = 0;    // Failed properties so far

    // Host strobes and ack must stay out of the CPU half
    bridge_idle_in_cpu_slot: assert property (@(posedge clock_i) disable iff (!reset_ni)
        cpu_be_i |-> !(bridge_oe_i || bridge_we_i || ack_i))
        else begin
            violation_count++;
            $error("Bridge is active while cpu_be is high");
        end

    io_ram_exclusive: assert property (@(posedge clock_i) disable iff (!reset_ni)
        !(io_oe_i && ram_oe_i))
        else begin
            violation_count++;
            $error("io_oe and ram_oe are high together");
        end

endmodule

bind pet_bus_top pet_bus_checker u_pet_bus_checker (
    .clock_i(sys_clock_i), .reset_ni(sys_reset_ni), .cpu_be_i(cpu_be_o),
    .bridge_oe_i(bridge_oe), .bridge_we_i(bridge_we), .io_oe_i(io_oe_o), .ram_oe_i(ram_oe_o),
    .ack_i(wb_ack_o)
);

`default_nettype wire

// File: verification/pet_bus_tb.sv
// Models a 6502-style CPU and a 128 KB RAM around the bus; the CPU reads only between tests
`default_nettype none

`include "pet_bus_macros.svh"

module pet_bus_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                       clk;
    logic                       rst_n;
    logic [`CPU_ADDR_WIDTH-1:0] cpu_addr;
    logic                       cpu_we;
    logic [    `DATA_WIDTH-1:0] cpu_wdata;      // What the CPU puts on the data bus
    logic                       cpu_be;
    logic                       cpu_clock;
    logic [`RAM_ADDR_WIDTH-1:0] wb_addr;
    logic [    `DATA_WIDTH-1:0] wb_wdata;
    logic [    `DATA_WIDTH-1:0] wb_rdata;
    logic                       wb_we;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_stall;
    logic                       wb_ack;
    logic [    `DATA_WIDTH-1:0] ram_rdata;
    logic [`RAM_ADDR_WIDTH-1:0] ram_addr;
    logic                       ram_oe;
    logic                       ram_we;
    logic [    `DATA_WIDTH-1:0] bus_data;
    logic                       bus_data_oe;
    logic                       io_oe;
    logic                       pia1_cs;
    logic                       pia2_cs;
    logic                       via_cs;
    logic                       crtc_cs;

    logic [`DATA_WIDTH-1:0] ram_mem [0:(1 << `RAM_ADDR_WIDTH)-1];
    logic [3:0]             frame;          // Own copy of the bus frame count
    int                     errors;
    int                     timeouts;

    clock_gen u_clock_gen (.clock_o(clk), .reset_no(rst_n));

    pet_bus_top u_pet_bus_top (
        .sys_clock_i(clk), .sys_reset_ni(rst_n), .cpu_addr_i(cpu_addr), .cpu_we_i(cpu_we),
        .cpu_be_o(cpu_be), .cpu_clock_o(cpu_clock), .wb_addr_i(wb_addr), .wb_data_i(wb_wdata),
        .wb_we_i(wb_we), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_data_o(wb_rdata),
        .wb_stall_o(wb_stall), .wb_ack_o(wb_ack), .ram_data_i(ram_rdata), .ram_addr_o(ram_addr),
        .ram_oe_o(ram_oe), .ram_we_o(ram_we), .cpu_data_o(bus_data),
        .cpu_data_oe_o(bus_data_oe), .io_oe_o(io_oe), .pia1_cs_o(pia1_cs),
        .pia2_cs_o(pia2_cs), .via_cs_o(via_cs), .crtc_cs_o(crtc_cs)
    );

    // RAM model
    assign ram_rdata = ram_oe ? ram_mem[ram_addr] : 8'hFF;

    always @(posedge clk) begin
        if (ram_we) ram_mem[ram_addr] <= bus_data_oe ? bus_data : cpu_wdata;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) frame <= '0;
        else        frame <= frame + 4'd1;
    end

    // Expected {ram_oe, ram_we, io_oe, pia1, pia2, via, crtc} for a CPU cycle
    function automatic logic [6:0] expected_bus(input logic [15:0] addr, input logic we,
                                                input logic phase2);
        logic       io;
        logic       rom;
        logic [6:0] e;
        io     = (addr[15:8] == 8'hE8);
        rom    = (addr >= 16'h9000);
        e[6]   = !io && !we;
        e[5]   = !io && we && !rom && phase2;   // ROM and phase 1 writes are dropped
        e[4]   = io;
        e[3:0] = io ? {addr[4], addr[5], addr[6], addr[7]} : 4'b0000;
        return e;
    endfunction

    always @(posedge clk) begin
        logic [6:0] expected;
        logic [6:0] observed;
        if (rst_n) begin
            observed = {ram_oe, ram_we, io_oe, pia1_cs, pia2_cs, via_cs, crtc_cs};
            if (cpu_be !== (frame >= 4'd8) || cpu_clock !== (frame >= 4'd12)) begin
                $display("ERR %0t: cpu_be %b cpu_clock %b at frame count %0d",
                         $time, cpu_be, cpu_clock, frame);
                errors++;
            end
            if (frame >= 4'd8) begin
                expected = expected_bus(cpu_addr, cpu_we, frame >= 4'd12);
                if (observed !== expected || ram_addr !== {1'b0, cpu_addr}) begin
                    $display("ERR %0t: outputs %b addr %h, expected %b for %h we %b",
                             $time, observed, ram_addr, expected, cpu_addr, cpu_we);
                    errors++;
                end
                if (cpu_we && cpu_addr >= 16'h9000 && ram_we) begin
                    $display("ERR %0t: ROM write at %h reached the RAM", $time, cpu_addr);
                    errors++;
                end
            end else if (observed[4:0] !== 5'b0) begin
                $display("ERR %0t: chip select high in host slot", $time);
                errors++;
            end
        end
    end

    // One Wishbone access, with acceptance and ack timing checks
    task automatic host_access(input logic we, input logic [16:0] addr, input logic [7:0] wdata,
                               output logic [7:0] rdata, output logic ok);
        int wait_cycles;
        int ack_delay;
        ok    = 1'b0;
        rdata = '0;
        @(negedge clk);
        wb_addr  = addr;
        wb_wdata = wdata;
        wb_we    = we;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wait_cycles = 0;
        do begin
            @(posedge clk);
            wait_cycles++;
        end while (wb_stall && wait_cycles < 40);
        if (wb_stall) begin
            $display("Host request at %h was never accepted (%0t)", addr, $time);
            timeouts++;
            return;
        end
        if (frame != 4'd0) begin
            $display("ERR %0t: request accepted at frame count %0d", $time, frame);
            errors++;
        end
        @(negedge clk);
        wb_stb    = 1'b0;
        ack_delay = 0;
        do begin
            @(posedge clk);
            ack_delay++;
            // Frame counts 1 to 4 carry the RAM cycle
            if (ack_delay <= 4 && (bus_data_oe !== we || (we && bus_data !== wdata))) begin
                $display("ERR %0t: data bus %h oe %b during host access",
                         $time, bus_data, bus_data_oe);
                errors++;
            end
        end while (!wb_ack && ack_delay < 20);
        if (!wb_ack) begin
            $display("No ack came for the host request at %h (%0t)", addr, $time);
            timeouts++;
            return;
        end
        if (ack_delay != 5) begin
            $display("ERR %0t: ack %0d cycles after acceptance", $time, ack_delay);
            errors++;
        end
        rdata = wb_rdata;
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_we  = 1'b0;
        ok     = 1'b1;
    endtask

    task automatic after_reset();
        int n;
        @(negedge clk);
        if (cpu_be !== 1'b0 || ram_oe !== 1'b0 || ram_we !== 1'b0 || wb_ack !== 1'b0 ||
            wb_stall !== 1'b1 || {io_oe, pia1_cs, pia2_cs, via_cs, crtc_cs} !== 5'b0) begin
            $display("ERR %0t: outputs not at their reset values", $time);
            errors++;
        end
        n = 0;
        while (!rst_n && n < 40) begin
            @(posedge clk);
            n++;
        end
        if (!rst_n) begin
            $display("Reset was never released");
            timeouts++;
        end
    endtask

    task automatic random_cpu_accesses(input int count);
        logic [`CPU_ADDR_WIDTH-1:0] addr;
        repeat (count) begin
            @(negedge clk);
            addr = 16'($urandom);
            if ($urandom_range(0, 3) == 0) addr[15:8] = 8'hE8;   // Visit the I/O page often
            cpu_addr  = addr;
            cpu_we    = 1'($urandom);
            cpu_wdata = 8'($urandom);
        end
        @(negedge clk);
        cpu_we = 1'b0;
    endtask

    task automatic host_round_trip();
        logic [16:0] addr [8];
        logic [7:0]  data [8];
        logic [7:0]  rd;
        logic        ok;
        for (int i = 0; i < 8; i++) begin
            addr[i]      = 17'($urandom);
            addr[i][2:0] = 3'(i);           // Keeps the addresses distinct
            data[i]      = 8'($urandom);
        end
        addr[0][16:12] = 5'h0B;             // Inside the CPU ROM region
        for (int i = 0; i < 8; i++) begin
            host_access(1'b1, addr[i], data[i], rd, ok);
            if (!ok) return;
        end
        for (int i = 0; i < 8; i++) begin
            host_access(1'b0, addr[i], 8'h00, rd, ok);
            if (!ok) return;
            if (rd !== data[i]) begin
                $display("ERR %0t: host read %h gave %h, wrote %h", $time, addr[i], rd, data[i]);
                errors++;
            end
        end
    endtask

    task automatic request_timing();
        logic [16:0] addr;
        logic [7:0]  rd;
        logic        ok;
        repeat (6) begin
            repeat ($urandom_range(0, 15)) @(negedge clk);
            addr = 17'($urandom);
            host_access(1'b0, addr, 8'h00, rd, ok);
            if (!ok) return;
            if (rd !== ram_mem[addr]) begin
                $display("ERR %0t: host read %h gave %h", $time, addr, rd);
                errors++;
            end
            repeat (16) begin
                @(posedge clk);
                if (wb_ack) begin
                    $display("ERR %0t: second ack for one request", $time);
                    errors++;
                end
            end
        end
    endtask

    task automatic shared_ram();
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  rd;
        logic        ok;
        int          n;
        repeat (4) begin
            addr = 16'($urandom_range(0, 16'h8FFF));
            data = 8'($urandom);
            @(negedge clk);
            cpu_addr  = addr;
            cpu_we    = 1'b1;
            cpu_wdata = data;
            n = 0;
            do begin
                @(posedge clk);
                n++;
            end while (frame != 4'd15 && n < 40);   // Last phase 2 edge
            if (frame != 4'd15) begin
                $display("The CPU write window never came");
                timeouts++;
                return;
            end
            @(negedge clk);
            cpu_we = 1'b0;
            host_access(1'b0, {1'b0, addr}, 8'h00, rd, ok);
            if (!ok) return;
            if (rd !== data) begin
                $display("ERR %0t: host read %h gave %h, CPU wrote %h", $time, addr, rd, data);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before && timeouts == 0) $display("Test %s: ok", name);
        else $display("Test %s: %0d errors, %0d timeouts", name, errors - errors_before, timeouts);
    endtask

    task automatic run_tests();
        int first;
        first = errors;
        after_reset();
        report_test("after reset", first);
        if (timeouts != 0) return;
        first = errors;
        random_cpu_accesses(400);
        report_test("random CPU accesses", first);
        first = errors;
        host_round_trip();
        report_test("host round trip", first);
        if (timeouts != 0) return;
        first = errors;
        request_timing();
        report_test("request timing", first);
        if (timeouts != 0) return;
        first = errors;
        shared_ram();
        report_test("CPU and host share RAM", first);
    endtask

    initial begin
        int asserts;
        errors    = 0;
        timeouts  = 0;
        cpu_addr  = '0;
        cpu_we    = 1'b0;
        cpu_wdata = '0;
        wb_addr   = '0;
        wb_wdata  = '0;
        wb_we     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        void'($urandom(6));
        for (int i = 0; i < (1 << `RAM_ADDR_WIDTH); i++) begin
            ram_mem[i] = 8'(i) ^ 8'(i >> 8) ^ {i[16], 7'd0};
        end
        run_tests();
        asserts = u_pet_bus_top.u_pet_bus_checker.violation_count;
        $display("Done: %0d check errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, asserts);
        if (errors == 0 && timeouts == 0 && asserts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
source/pet_bus_pkg.sv
source/wb_if.sv
source/slot_timer.sv
source/cpu_address_decoder.sv
source/wb_ram_bridge.sv
source/bus_combiner.sv
source/pet_bus_top.sv
verification/clock_gen.sv
verification/pet_bus_checker.sv
verification/pet_bus_tb.sv
